// ==== design/exStage_consts.svh ====
// Fixed constants of the execute stage; the multiplier step count must cover all 32 operand bits
`ifndef EX_STAGE_CONSTS_SVH
`define EX_STAGE_CONSTS_SVH

// --------------------------------------------------
// Datapath timing
// --------------------------------------------------
`define EX_MUL_CYCLES 32        // Shift-add steps per multiply

`define EX_PC_STEP 32'd4        // Byte distance between instructions

// --------------------------------------------------
// Testbench sizing
// --------------------------------------------------
`define EX_MAX_VECTORS 64       // Depth of the pattern memory

// Capture, start pulse and result register on top of the steps
`define EX_MAX_LATENCY (`EX_MUL_CYCLES + 3)

`endif

// ==== design/exPkg.sv ====
// Types shared by the execute stage and its testbench; field order fixes the pattern file layout
`default_nettype none

package exPkg;

    // --------------------------------------------------
    // Opcodes and states
    // --------------------------------------------------
    typedef enum logic [4:0] {
        OP_ADD   = 5'd0,
        OP_ADDU  = 5'd1,
        OP_SUB   = 5'd2,
        OP_SUBU  = 5'd3,
        OP_AND   = 5'd4,
        OP_OR    = 5'd5,
        OP_XOR   = 5'd6,
        OP_NOR   = 5'd7,
        OP_SLT   = 5'd8,
        OP_SLTU  = 5'd9,
        OP_SLL   = 5'd10,
        OP_SRL   = 5'd11,
        OP_SRA   = 5'd12,
        OP_MULT  = 5'd13,     // Signed, overwrites HI/LO
        OP_MULTU = 5'd14,
        OP_MADD  = 5'd15,     // Signed, adds into HI/LO
        OP_MFHI  = 5'd16,
        OP_MFLO  = 5'd17,
        OP_BEQ   = 5'd18,
        OP_BNE   = 5'd19,
        OP_J     = 5'd20,
        OP_JAL   = 5'd21
    } exOp_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_MUL  = 2'd1,
        ST_DONE = 2'd2
    } exState_t;

    // --------------------------------------------------
    // Records
    // --------------------------------------------------
    typedef struct packed {
        logic carry;
        logic zero;
        logic overflow;
        logic negative;
    } exFlags_t;

    typedef struct packed {
        exOp_t       op;
        logic [31:0] a;           // Register operand rs
        logic [31:0] b;           // Register operand rt
        logic [31:0] imm;         // Already sign-extended
        logic [31:0] pc;
        logic [4:0]  shamt;
        logic        useImm;      // imm replaces b at the ALU
        logic [4:0]  destReg;
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
    } exReq_t;

    typedef struct packed {
        logic [31:0] value;
        exFlags_t    flags;
        logic [31:0] nextPc;
        logic        branchTaken;
        logic [4:0]  destReg;     // Pass-through group
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
    } exResult_t;

endpackage

`default_nettype wire

// ==== design/exAlu.sv ====
// Combinational ALU; shifts act on the second operand (b or imm) and non-ALU opcodes give zero
`default_nettype none

module exAlu (
    input  wire exPkg::exOp_t   op,
    input  wire          [31:0] a,
    input  wire          [31:0] b,
    input  wire          [31:0] imm,
    input  wire                 useImm,
    input  wire          [4:0]  shamt,
    output logic         [31:0] value,
    output exPkg::exFlags_t     flags
);

    logic [31:0] opB;         // Second operand after immediate select
    logic [31:0] addend;      // Inverted operand when subtracting
    logic [32:0] sum;         // Bit 32 is the carry out of bit 31
    logic        isSub;
    logic        isAddSub;
    logic        isSignedArith;

    assign opB           = useImm ? imm : b;
    assign isSub         = (op == exPkg::OP_SUB) || (op == exPkg::OP_SUBU);
    assign isAddSub      = isSub || (op == exPkg::OP_ADD) || (op == exPkg::OP_ADDU);
    assign isSignedArith = (op == exPkg::OP_ADD) || (op == exPkg::OP_SUB);
    assign addend        = isSub ? ~opB : opB;

    // One adder serves both directions, a + ~b + 1 for subtract
    assign sum = {1'b0, a} + {1'b0, addend} + {32'd0, isSub};

    // --------------------------------------------------
    // Result value
    // --------------------------------------------------
    always_comb begin
        case (op)
            exPkg::OP_ADD,
            exPkg::OP_ADDU,
            exPkg::OP_SUB,
            exPkg::OP_SUBU: value = sum[31:0];
            exPkg::OP_AND:  value = a & opB;
            exPkg::OP_OR:   value = a | opB;
            exPkg::OP_XOR:  value = a ^ opB;
            exPkg::OP_NOR:  value = ~(a | opB);
            exPkg::OP_SLT:  value = {31'd0, $signed(a) < $signed(opB)};
            exPkg::OP_SLTU: value = {31'd0, a < opB};
            exPkg::OP_SLL:  value = opB << shamt;
            exPkg::OP_SRL:  value = opB >> shamt;
            exPkg::OP_SRA:  value = $unsigned($signed(opB) >>> shamt);
            default:        value = 32'd0;    // Not an ALU opcode
        endcase
    end

    // --------------------------------------------------
    // Flags
    // --------------------------------------------------
    always_comb begin
        flags.carry    = isAddSub & sum[32];
        // Same-sign inputs giving an opposite-sign sum
        flags.overflow = isSignedArith && (a[31] == addend[31]) && (sum[31] != a[31]);
        flags.zero     = (value == 32'd0);
        flags.negative = value[31];
    end

    // Unsigned and logic opcodes must never report signed overflow
    always_comb begin
        if (op inside {exPkg::OP_ADDU, exPkg::OP_SUBU, exPkg::OP_AND, exPkg::OP_OR,
                       exPkg::OP_XOR, exPkg::OP_NOR, exPkg::OP_SLTU}) begin
            assert (!flags.overflow)
                else $error("ALU overflow set for opcode %s", op.name());
        end
    end

endmodule

`default_nettype wire

// ==== design/exMulAcc.sv ====
// Shift-add multiplier with HI/LO; start must not arrive while busy, op and operands held until done
`default_nettype none
`include "exStage_consts.svh"

module exMulAcc (
    input  wire                 Clock,
    input  wire                 reset,
    input  wire                 start,
    input  wire exPkg::exOp_t   op,
    input  wire          [31:0] a,
    input  wire          [31:0] b,
    output logic                done,
    output logic         [63:0] hiLo
);

    logic        busy;
    logic [5:0]  stepCount;
    logic [63:0] mcand;        // Shifts left one place per step
    logic [31:0] mplier;       // Shifts right, bit 0 picks the add
    logic [63:0] partial;
    logic        negate;
    logic        accumulate;
    logic        isSigned;
    logic [31:0] magA;
    logic [31:0] magB;
    logic [63:0] stepSum;
    logic [63:0] product;
    logic        lastStep;

    assign isSigned = (op != exPkg::OP_MULTU);     // MADD is signed too
    assign magA     = (isSigned && a[31]) ? -a : a;
    assign magB     = (isSigned && b[31]) ? -b : b;
    assign stepSum  = partial + (mplier[0] ? mcand : 64'd0);
    assign product  = negate ? -stepSum : stepSum;
    assign lastStep = busy && (stepCount == 6'(`EX_MUL_CYCLES - 1));

    // --------------------------------------------------
    // Sequencing and accumulator
    // --------------------------------------------------
    always_ff @(posedge Clock) begin
        if (reset) begin
            busy      <= 1'b0;
            stepCount <= 6'd0;
            done      <= 1'b0;
            hiLo      <= 64'd0;
        end else begin
            done <= lastStep;                       // One-cycle pulse
            if (start) begin
                busy      <= 1'b1;
                stepCount <= 6'd0;
            end else if (lastStep) begin
                busy <= 1'b0;
                hiLo <= accumulate ? hiLo + product : product;
            end else if (busy) begin
                stepCount <= stepCount + 6'd1;
            end
        end
    end

    // --------------------------------------------------
    // Operand and partial product registers
    // --------------------------------------------------
    always_ff @(posedge Clock) begin
        if (start) begin
            mcand      <= {32'd0, magA};
            mplier     <= magB;
            partial    <= 64'd0;
            negate     <= isSigned && (a[31] ^ b[31]);
            accumulate <= (op == exPkg::OP_MADD);
        end else if (busy) begin
            partial <= stepSum;
            mcand   <= mcand << 1;
            mplier  <= mplier >> 1;
        end
    end

    // Launch from the controller only once the previous multiply has retired
    assert property (@(posedge Clock) disable iff (reset) start |-> !busy)
        else $error("Multiplier started while busy");

endmodule

`default_nettype wire

// ==== design/exBranch.sv ====
// Branch and jump resolution; jump targets are absolute byte addresses taken from imm
`default_nettype none
`include "exStage_consts.svh"

module exBranch (
    input  wire exPkg::exOp_t   op,
    input  wire          [31:0] a,
    input  wire          [31:0] b,
    input  wire          [31:0] imm,
    input  wire          [31:0] pc,
    output logic         [31:0] nextPc,
    output logic                taken,
    output logic         [31:0] linkValue
);

    logic [31:0] branchTarget;
    logic        operandsEqual;

    assign linkValue     = pc + `EX_PC_STEP;              // Also the fall-through PC
    assign branchTarget  = linkValue + {imm[29:0], 2'b00}; // Word offset
    assign operandsEqual = (a == b);

    // --------------------------------------------------
    // Next PC select
    // --------------------------------------------------
    always_comb begin
        taken  = 1'b0;
        nextPc = linkValue;
        case (op)
            exPkg::OP_BEQ: begin
                taken  = operandsEqual;
                nextPc = operandsEqual ? branchTarget : linkValue;
            end
            exPkg::OP_BNE: begin
                taken  = !operandsEqual;
                nextPc = operandsEqual ? linkValue : branchTarget;
            end
            exPkg::OP_J,
            exPkg::OP_JAL: begin
                taken  = 1'b1;
                nextPc = imm;
            end
            default: begin
                taken  = 1'b0;                       // Sequential flow
                nextPc = linkValue;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/exControl.sv ====
// Four-phase handshake FSM; reqData is sampled on the first edge req is high, one op in flight
`default_nettype none

module exControl (
    input  wire                   Clock,
    input  wire                   reset,
    input  wire                   req,
    input  wire exPkg::exReq_t    reqData,
    input  wire            [31:0] aluValue,
    input  wire exPkg::exFlags_t  aluFlags,
    input  wire            [31:0] nextPc,
    input  wire                   taken,
    input  wire            [31:0] linkValue,
    input  wire            [63:0] hiLo,
    input  wire                   mulDone,
    output logic                  ack,
    output exPkg::exResult_t      result,
    output exPkg::exReq_t         curReq,
    output logic                  mulStart
);

    exPkg::exState_t  state;
    exPkg::exResult_t nextResult;
    logic             isMulReq;
    logic             loadResult;

    assign isMulReq   = reqData.op inside {exPkg::OP_MULT, exPkg::OP_MULTU, exPkg::OP_MADD};
    // ALU path registers right after capture, multiply path on mulDone
    assign loadResult = ((state == exPkg::ST_MUL) && mulDone) ||
                        ((state == exPkg::ST_DONE) && !ack);

    // --------------------------------------------------
    // Result select by opcode class
    // --------------------------------------------------
    always_comb begin
        nextResult             = '0;
        nextResult.nextPc      = nextPc;
        nextResult.branchTaken = taken;
        nextResult.destReg     = curReq.destReg;      // Pass-through
        nextResult.regWrite    = curReq.regWrite;
        nextResult.memRead     = curReq.memRead;
        nextResult.memWrite    = curReq.memWrite;
        case (curReq.op)
            exPkg::OP_MULT,
            exPkg::OP_MULTU,
            exPkg::OP_MADD: begin
                nextResult.value          = hiLo[31:0];
                nextResult.flags.zero     = (hiLo == 64'd0);    // Whole accumulator
                nextResult.flags.negative = hiLo[63];
            end
            exPkg::OP_MFHI: begin
                nextResult.value          = hiLo[63:32];
                nextResult.flags.zero     = (hiLo[63:32] == 32'd0);
                nextResult.flags.negative = hiLo[63];
            end
            exPkg::OP_MFLO: begin
                nextResult.value          = hiLo[31:0];
                nextResult.flags.zero     = (hiLo[31:0] == 32'd0);
                nextResult.flags.negative = hiLo[31];
            end
            exPkg::OP_JAL: nextResult.value = linkValue;  // Flags stay clear
            exPkg::OP_BEQ,
            exPkg::OP_BNE,
            exPkg::OP_J:   nextResult.value = 32'd0;
            default: begin
                nextResult.value = aluValue;
                nextResult.flags = aluFlags;
            end
        endcase
    end

    // --------------------------------------------------
    // Handshake FSM
    // --------------------------------------------------
    always_ff @(posedge Clock) begin
        if (reset) begin
            state    <= exPkg::ST_IDLE;
            ack      <= 1'b0;
            mulStart <= 1'b0;
        end else begin
            mulStart <= 1'b0;
            case (state)
                exPkg::ST_IDLE: begin
                    if (req) begin
                        state    <= isMulReq ? exPkg::ST_MUL : exPkg::ST_DONE;
                        mulStart <= isMulReq;       // Pulses the cycle after capture
                    end
                end
                exPkg::ST_MUL: begin
                    if (mulDone) begin
                        state <= exPkg::ST_DONE;
                        ack   <= 1'b1;
                    end
                end
                exPkg::ST_DONE: begin
                    if (!ack) begin
                        ack <= 1'b1;                // ALU result now registered
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= exPkg::ST_IDLE;
                    end
                end
                default: state <= exPkg::ST_IDLE;
            endcase
        end
    end

    // Request and result payload
    always_ff @(posedge Clock) begin
        if ((state == exPkg::ST_IDLE) && req) begin
            curReq <= reqData;
        end
        if (loadResult) begin
            result <= nextResult;
        end
    end

    assert property (@(posedge Clock) disable iff (reset) $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // Multiplier completion only while a multiply is outstanding
    assert property (@(posedge Clock) disable iff (reset) mulDone |-> (state == exPkg::ST_MUL))
        else $error("mulDone outside ST_MUL");

    assert property (@(posedge Clock) disable iff (reset)
                     (req && $past(req) && !ack) |-> $stable(reqData))
        else $error("reqData changed before ack");

endmodule

`default_nettype wire

// ==== design/exStage.sv ====
// Execute stage top; single operation in flight under a four-phase req/ack handshake
`default_nettype none

module exStage (
    input  wire                  Clock,
    input  wire                  reset,
    input  wire                  req,
    input  wire exPkg::exReq_t   reqData,
    output logic                 ack,
    output exPkg::exResult_t     result
);

    exPkg::exReq_t   curReq;        // Captured request
    exPkg::exFlags_t aluFlags;
    logic [31:0]     aluValue;
    logic [31:0]     nextPc;
    logic [31:0]     linkValue;
    logic            taken;
    logic [63:0]     hiLo;
    logic            mulStart;
    logic            mulDone;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    exControl exControl_i (
        .Clock    (Clock    ),
        .reset    (reset    ),
        .req      (req      ),
        .reqData  (reqData  ),
        .aluValue (aluValue ),
        .aluFlags (aluFlags ),
        .nextPc   (nextPc   ),
        .taken    (taken    ),
        .linkValue(linkValue),
        .hiLo     (hiLo     ),
        .mulDone  (mulDone  ),
        .ack      (ack      ),
        .result   (result   ),
        .curReq   (curReq   ),
        .mulStart (mulStart )
    );

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    exAlu exAlu_i (
        .op    (curReq.op    ),
        .a     (curReq.a     ),
        .b     (curReq.b     ),
        .imm   (curReq.imm   ),
        .useImm(curReq.useImm),
        .shamt (curReq.shamt ),
        .value (aluValue     ),
        .flags (aluFlags     )
    );

    exMulAcc exMulAcc_i (
        .Clock(Clock    ),
        .reset(reset    ),
        .start(mulStart ),
        .op   (curReq.op),
        .a    (curReq.a ),          // Multiplies always use registers
        .b    (curReq.b ),
        .done (mulDone  ),
        .hiLo (hiLo     )
    );

    exBranch exBranch_i (
        .op       (curReq.op ),
        .a        (curReq.a  ),
        .b        (curReq.b  ),
        .imm      (curReq.imm),
        .pc       (curReq.pc ),
        .nextPc   (nextPc    ),
        .taken    (taken     ),
        .linkValue(linkValue )
    );

endmodule

`default_nettype wire

// ==== verif/exStageChecker.sv ====
// Samples on rising edges; expResult must be set before req rises and held until ack falls
`default_nettype none
`include "exStage_consts.svh"

module exStageChecker (
    input  wire                    Clock,
    input  wire                    reset,
    input  wire                    req,
    input  wire exPkg::exReq_t     reqData,
    input  wire                    ack,
    input  wire exPkg::exResult_t  result,
    input  wire exPkg::exResult_t  expResult,
    output int                     mismatchCount,
    output int                     protocolCount,
    output int                     checkedCount
);

    logic             reqPrev;
    logic             ackPrev;
    logic             resetPrev;
    exPkg::exResult_t resultPrev;
    int               cycleCount;
    int               riseCycle;      // Sample that captured the request
    int               reqLowCycles;
    int               latency;
    int               expLatency;

    initial begin
        mismatchCount = 0;
        protocolCount = 0;
        checkedCount  = 0;
        reqPrev       = 1'b0;
        ackPrev       = 1'b0;
        resetPrev     = 1'b0;
        cycleCount    = 0;
        riseCycle     = 0;
        reqLowCycles  = 0;
    end

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic reportProtocol(input string what);
        $display("Protocol error at %0t: %s", $time, what);
        protocolCount++;
    endtask

    // --------------------------------------------------
    // Result comparison on the first cycle of ack
    // --------------------------------------------------
    task automatic compareResult();
        checkedCount++;
        compareField("result.value", result.value, expResult.value);
        compareField("result.flags.carry", 32'(result.flags.carry), 32'(expResult.flags.carry));
        compareField("result.flags.zero", 32'(result.flags.zero), 32'(expResult.flags.zero));
        compareField("result.flags.overflow", 32'(result.flags.overflow),
                     32'(expResult.flags.overflow));
        compareField("result.flags.negative", 32'(result.flags.negative),
                     32'(expResult.flags.negative));
        compareField("result.nextPc", result.nextPc, expResult.nextPc);
        compareField("result.branchTaken", 32'(result.branchTaken), 32'(expResult.branchTaken));
        compareField("result.destReg", 32'(result.destReg), 32'(expResult.destReg));
        compareField("result.regWrite", 32'(result.regWrite), 32'(expResult.regWrite));
        compareField("result.memRead", 32'(result.memRead), 32'(expResult.memRead));
        compareField("result.memWrite", 32'(result.memWrite), 32'(expResult.memWrite));
    endtask

    // --------------------------------------------------
    // Handshake order
    // --------------------------------------------------
    always @(posedge Clock) begin
        if (reset && resetPrev && ack === 1'b1) begin
            reportProtocol("ack is high while reset is held");
        end
        if (!reset) begin
            if (ack && !ackPrev) begin
                if (!reqPrev) begin
                    reportProtocol("ack rose although req was low");
                end else begin
                    latency    = cycleCount - riseCycle - 1;
                    // Multiplies take the step count plus start and done cycles
                    expLatency = (reqData.op inside {exPkg::OP_MULT, exPkg::OP_MULTU,
                                  exPkg::OP_MADD}) ? `EX_MUL_CYCLES + 2 : 1;
                    if (latency != expLatency) begin
                        $display("Protocol error at %0t: ack came %0d cycles after capture, not %0d",
                                 $time, latency, expLatency);
                        protocolCount++;
                    end
                end
                compareResult();
            end
            if (!ack && ackPrev && reqPrev) begin
                reportProtocol("ack fell while req was still high");
            end
            if (ack && ackPrev && result !== resultPrev) begin
                reportProtocol("result changed while ack was held");
            end
            if (ack && !req && reqLowCycles >= 1) begin
                reportProtocol("ack still high two cycles after req dropped");
            end
        end
        if (req && !reqPrev) begin
            riseCycle <= cycleCount;
        end
        reqLowCycles <= req ? 0 : reqLowCycles + 1;
        cycleCount   <= cycleCount + 1;
        reqPrev      <= req;
        ackPrev      <= ack;
        resetPrev    <= reset;
        resultPrev   <= result;
    end

endmodule

`default_nettype wire

// ==== verif/exStageTb.sv ====
// Run from the project root so the pattern path resolves; expected values come from that file only
`default_nettype none
`include "exStage_consts.svh"

module exStageTb;

    // --------------------------------------------------
    // Pattern record, one hex line per vector
    // --------------------------------------------------
    typedef struct packed {
        logic [7:0]  marker;      // 01 pulses reset first
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [7:0]  shamt;
        logic [3:0]  useImm;
        logic [7:0]  destReg;
        logic [3:0]  ctl;         // {0, regWrite, memRead, memWrite}
        logic [31:0] value;
        logic [3:0]  flags;       // carry, zero, overflow, negative
        logic [31:0] nextPc;
        logic [3:0]  taken;
    } patternRec_t;

    logic             Clock;
    logic             reset;
    logic             req;
    exPkg::exReq_t    reqData;
    logic             ack;
    exPkg::exResult_t result;
    exPkg::exResult_t expResult;
    logic [239:0]     patterns [0:`EX_MAX_VECTORS-1];
    int               numVectors;
    int               tbErrors;
    int               mismatchCount;
    int               protocolCount;
    int               checkedCount;
    logic             loaded;
    logic [31:0]      lcgState;

    always #20 Clock = ~Clock;

    exStage exStage_i (
        .Clock  (Clock  ),
        .reset  (reset  ),
        .req    (req    ),
        .reqData(reqData),
        .ack    (ack    ),
        .result (result )
    );

    exStageChecker exStageChecker_i (
        .Clock        (Clock        ),
        .reset        (reset        ),
        .req          (req          ),
        .reqData      (reqData      ),
        .ack          (ack          ),
        .result       (result       ),
        .expResult    (expResult    ),
        .mismatchCount(mismatchCount),
        .protocolCount(protocolCount),
        .checkedCount (checkedCount )
    );

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper bits of the LCG give a 0 to 7 cycle delay
    function automatic int drawDelay();
        lcgState = nextRandom(lcgState);
        return int'(lcgState[30:28]);
    endfunction

    task automatic pulseReset();
        @(posedge Clock);
        reset <= 1'b1;
        repeat (3) @(posedge Clock);
        reset <= 1'b0;
    endtask

    // --------------------------------------------------
    // One four-phase transfer
    // --------------------------------------------------
    task automatic runVector(input int idx);
        patternRec_t      vec;
        exPkg::exReq_t    nextReq;
        exPkg::exResult_t nextExp;
        int               gap;
        int               hold;
        vec              = patterns[idx];
        nextReq.op       = exPkg::exOp_t'(vec.op[4:0]);
        nextReq.a        = vec.a;
        nextReq.b        = vec.b;
        nextReq.imm      = vec.imm;
        nextReq.pc       = vec.pc;
        nextReq.shamt    = vec.shamt[4:0];
        nextReq.useImm   = vec.useImm[0];
        nextReq.destReg  = vec.destReg[4:0];
        nextReq.regWrite = vec.ctl[2];
        nextReq.memRead  = vec.ctl[1];
        nextReq.memWrite = vec.ctl[0];
        nextExp.value       = vec.value;
        nextExp.flags       = vec.flags;
        nextExp.nextPc      = vec.nextPc;
        nextExp.branchTaken = vec.taken[0];
        nextExp.destReg     = nextReq.destReg;       // Control fields pass through
        nextExp.regWrite    = nextReq.regWrite;
        nextExp.memRead     = nextReq.memRead;
        nextExp.memWrite    = nextReq.memWrite;
        if (vec.marker == 8'h01) begin
            pulseReset();                            // Clears HI/LO
        end
        gap = drawDelay();
        repeat (gap) @(posedge Clock);
        @(posedge Clock);
        expResult <= nextExp;
        reqData   <= nextReq;
        req       <= 1'b1;
        do @(posedge Clock); while (ack !== 1'b1);
        hold = drawDelay();
        repeat (hold) @(posedge Clock);              // Back-pressure
        req <= 1'b0;
        do @(posedge Clock); while (ack !== 1'b0);
    endtask

    initial begin
        int idx;
        Clock      = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        reqData    = '0;
        expResult  = '0;
        numVectors = 0;
        tbErrors   = 0;
        loaded     = 1'b0;
        lcgState   = 32'h542c_ebd5;
        for (idx = 0; idx < `EX_MAX_VECTORS; idx++) begin
            patterns[idx] = '1;                      // Marker FF ends the list
        end
        $readmemh("verif/exStage_patterns.mem", patterns);
        while (numVectors < `EX_MAX_VECTORS && patterns[numVectors][239:232] != 8'hFF) begin
            numVectors++;
        end
        loaded = 1'b1;
        repeat (3) @(posedge Clock);
        reset <= 1'b0;
        for (idx = 0; idx < numVectors; idx++) begin
            runVector(idx);
        end
        repeat (2) @(posedge Clock);
        if (numVectors == 0 || checkedCount != numVectors) begin
            $display("Only %0d results were checked for %0d vectors", checkedCount, numVectors);
            tbErrors++;
        end
        $display("Error counts: %0d mismatch, %0d protocol", mismatchCount,
                 protocolCount + tbErrors);
        if (mismatchCount == 0 && protocolCount == 0 && tbErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial begin
        wait (loaded);
        repeat (numVectors * (`EX_MAX_LATENCY + 20)) @(posedge Clock);
        $display("Timeout: the handshake stalled before all vectors completed");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/exPkg.sv
design/exAlu.sv
design/exMulAcc.sv
design/exBranch.sv
design/exControl.sv
design/exStage.sv
verif/exStageChecker.sv
verif/exStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exStageTb -f compile.f

simOutput=$(./obj_dir/VexStageTb 2>&1) || true
printf '%s\n' "$simOutput"

if printf '%s\n' "$simOutput" | grep -qx 'All tests passed'; then
    exit 0
fi
exit 1

// ==== verif/exStage_patterns.mem ====
// marker_op_a_b_imm_pc_shamt_useImm_destReg_{0,regWrite,memRead,memWrite}_value_{c,z,v,n}_nextPc_taken
// marker 01 pulses reset before its request, which clears HI/LO
// ALU add and subtract
00_00_00000005_00000003_00000000_00400000_00_0_08_4_00000008_0_00400004_0
00_00_7FFFFFFF_00000001_00000000_00400004_00_0_09_4_80000000_3_00400008_0
00_00_FFFFFFFF_12345678_FFFFFFFF_00400008_00_1_0A_6_FFFFFFFE_9_0040000C_0
00_01_FFFFFFFF_00000000_00000001_0040000C_00_1_0B_4_00000000_C_00400010_0
00_01_7FFFFFFF_00000001_00000000_00400010_00_0_0C_4_80000000_1_00400014_0
00_02_00000003_00000005_00000000_00400014_00_0_0D_4_FFFFFFFE_1_00400018_0
00_02_80000000_00000001_00000000_00400018_00_0_0E_4_7FFFFFFF_A_0040001C_0
00_02_0000002A_00000000_0000002A_0040001C_00_1_00_1_00000000_C_00400020_0
00_03_00000000_00000001_00000000_00400020_00_0_0F_4_FFFFFFFF_1_00400024_0
00_03_00000010_00000000_00000004_00400024_00_1_10_4_0000000C_8_00400028_0
// ALU logic
00_04_F0F0F0F0_FF00FF00_00000000_00400028_00_0_11_4_F000F000_1_0040002C_0
00_04_0000FFFF_00000000_FFFF0000_0040002C_00_1_12_4_00000000_4_00400030_0
00_05_12340000_00005678_00000000_00400030_00_0_13_4_12345678_0_00400034_0
00_05_00000000_00000000_80000000_00400034_00_1_14_4_80000000_1_00400038_0
00_06_AAAAAAAA_AAAAAAAA_00000000_00400038_00_0_15_4_00000000_4_0040003C_0
00_06_0F0F0F0F_00000000_FFFFFFFF_0040003C_00_1_16_4_F0F0F0F0_1_00400040_0
00_07_00000000_00000000_00000000_00400040_00_0_17_4_FFFFFFFF_1_00400044_0
00_07_FFFF0000_00000000_0000FFFF_00400044_00_1_18_4_00000000_4_00400048_0
// Compares and shifts
00_08_FFFFFFFF_00000001_00000000_00400048_00_0_19_4_00000001_0_0040004C_0
00_08_7FFFFFFF_00000000_80000000_0040004C_00_1_1A_4_00000000_4_00400050_0
00_09_FFFFFFFF_00000001_00000000_00400050_00_0_1B_4_00000000_4_00400054_0
00_09_00000000_00000000_FFFFFFFF_00400054_00_1_1C_4_00000001_0_00400058_0
00_0A_00000000_00000001_00000000_00400058_1F_0_1D_4_80000000_1_0040005C_0
00_0B_00000000_80000000_00000000_0040005C_1F_0_1E_4_00000001_0_00400060_0
00_0C_00000000_80000000_00000000_00400060_1F_0_1F_4_FFFFFFFF_1_00400064_0
// Multiply, accumulate and HI/LO moves
00_0E_FFFFFFFF_FFFFFFFF_00000000_00400064_00_0_00_0_00000001_1_00400068_0
00_10_00000000_00000000_00000000_00400068_00_0_02_4_FFFFFFFE_1_0040006C_0
00_11_00000000_00000000_00000000_0040006C_00_0_03_4_00000001_0_00400070_0
00_0D_FFFFFFFE_00000003_00000000_00400070_00_0_00_0_FFFFFFFA_1_00400074_0
00_0F_00000004_00000002_00000000_00400074_00_0_00_0_00000002_0_00400078_0
00_0F_80000000_80000000_00000000_00400078_00_0_00_0_00000002_0_0040007C_0
00_10_00000000_00000000_00000000_0040007C_00_0_04_4_40000000_0_00400080_0
00_11_00000000_00000000_00000000_00400080_00_0_05_4_00000002_0_00400084_0
01_10_00000000_00000000_00000000_00400084_00_0_06_4_00000000_4_00400088_0
00_11_00000000_00000000_00000000_00400088_00_0_07_4_00000000_4_0040008C_0
// Branches and jumps
00_12_00000007_00000007_00000010_0040008C_00_0_00_0_00000000_0_004000D0_1
00_12_00000007_00000008_00000010_00400090_00_0_00_0_00000000_0_00400094_0
00_13_00000001_00000002_FFFFFFFE_00400094_00_0_00_0_00000000_0_00400090_1
00_13_00000005_00000005_FFFFFFFE_00400098_00_0_00_0_00000000_0_0040009C_0
00_14_00000000_00000000_00400100_0040009C_00_0_00_0_00000000_0_00400100_1
00_15_00000000_00000000_00400200_004000A0_00_0_1F_4_004000A4_0_00400200_1
